/* include/mam_config.svh */
/*
 * Build-time configuration of the memory access path:
 * data, address and beat-count widths, memory depth and
 * the number of Wishbone wait states of the memory
 */
`ifndef MAM_CONFIG_SVH
`define MAM_CONFIG_SVH

`define MAM_DATA_WIDTH 16                      // Bus width in bits, 8, 16 or 32
`define MAM_SEL_WIDTH (`MAM_DATA_WIDTH / 8)    // Byte lanes per word
`define MAM_ADDR_WIDTH 32                      // Byte address width
`define MAM_BEATS_WIDTH 14                     // Burst length field, 1 to 16383

`define MAM_MEM_WORDS_LOG2 8                   // Memory depth in words, log2
`define MAM_WB_WAIT 1                          // Wait cycles before ack, 0 allowed

`endif

/* rtl/mam_pkg.sv */
/*
 * Shared types of the memory access path:
 * Wishbone cycle type identifiers and request operation
 */
package mam_pkg;

   // Wishbone B3 cycle type identifier, only the encodings in use
   typedef enum logic [2:0] {
      CTI_CLASSIC = 3'b000,   // Classic cycle, idle value
      CTI_INCR    = 3'b010,   // Incrementing burst beat
      CTI_EOB     = 3'b111    // Last beat of a burst or single access
   } wb_cti_t;

   // Direction of a memory request
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mam_op_t;

endpackage

/* rtl/mam_req_if.sv */
/*
 * Memory request channel between a host-side agent and the
 * Wishbone master engine, valid/ready handshake with
 * initiator and target modports
 */
`timescale 1ns/1ns
`include "mam_config.svh"

interface mam_req_if import mam_pkg::*; ();

   logic                        req_valid;   // Request present, fields stable
   logic                        req_ready;   // Engine idle and able to accept
   mam_op_t                     op;          // Read or write
   logic [`MAM_ADDR_WIDTH-1:0]  addr;        // Byte base address
   logic                        burst;       // Incrementing burst when set
   logic [`MAM_BEATS_WIDTH-1:0] beats;       // Burst length in words

   modport initiator (
      output req_valid,
      output op,
      output addr,
      output burst,
      output beats,
      input  req_ready
   );

   modport target (
      input  req_valid,
      input  op,
      input  addr,
      input  burst,
      input  beats,
      output req_ready
   );

endinterface

/* rtl/wb_bus_if.sv */
/*
 * Wishbone B3 point-to-point bus with registered feedback
 * cycle types, master and slave modports
 */
`timescale 1ns/1ns
`include "mam_config.svh"

interface wb_bus_if import mam_pkg::*; ();

   logic                        cyc;       // Bus cycle in progress
   logic                        stb;       // Beat strobe
   logic                        we;        // Write enable
   logic [`MAM_ADDR_WIDTH-1:0]  addr;      // Byte address
   logic [`MAM_DATA_WIDTH-1:0]  dat_m2s;   // Write data
   logic [`MAM_SEL_WIDTH-1:0]   sel;       // Byte lane select
   wb_cti_t                     cti;       // Cycle type identifier
   logic [1:0]                  bte;       // Burst type, linear only
   logic [`MAM_DATA_WIDTH-1:0]  dat_s2m;   // Read data
   logic                        ack;       // Beat acknowledge

   modport master (
      output cyc,
      output stb,
      output we,
      output addr,
      output dat_m2s,
      output sel,
      output cti,
      output bte,
      input  dat_s2m,
      input  ack
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  addr,
      input  dat_m2s,
      input  sel,
      input  cti,
      input  bte,
      output dat_s2m,
      output ack
   );

endinterface

/* rtl/mam_wb_master.sv */
/*
 * Wishbone master engine of the memory access path.
 * Turns requests plus write and read stream beats into
 * single and incrementing burst Wishbone cycles
 */
`timescale 1ns/1ns
`include "mam_config.svh"

module mam_wb_master import mam_pkg::*; (
   input  logic                       clk_i,
   input  logic                       rst_i,

   mam_req_if.target                  req,

   input  logic                       write_valid_i,
   input  logic [`MAM_DATA_WIDTH-1:0] write_data_i,
   input  logic [`MAM_SEL_WIDTH-1:0]  write_strb_i,   // Used on single writes only
   output logic                       write_ready_o,

   output logic                       read_valid_o,
   output logic [`MAM_DATA_WIDTH-1:0] read_data_o,
   input  logic                       read_ready_i,

   wb_bus_if.master                   wb
);

   localparam logic [`MAM_ADDR_WIDTH-1:0]  ADDR_STEP = `MAM_SEL_WIDTH;   // Bytes per word
   localparam logic [`MAM_BEATS_WIDTH-1:0] BEATS_ONE = 1;

   typedef enum logic [3:0] {
      S_IDLE,
      S_WRITE,             // Non-final write beat on the bus
      S_WRITE_WAIT,        // Waiting for a non-final write beat
      S_WRITE_LAST,        // Final write beat on the bus
      S_WRITE_LAST_WAIT,   // Waiting for the final write beat
      S_READ_START,
      S_READ,              // Non-final read beat on the bus
      S_READ_WAIT,         // Read beat offered while the bus pauses
      S_READ_LAST_BURST,   // Final read beat on the bus
      S_READ_LAST_WAIT     // Final read beat offered
   } state_t;

   state_t                       state_q, state_d;
   logic                         cyc_q, cyc_d;
   logic                         stb_q, stb_d;
   logic                         we_q, we_d;
   wb_cti_t                      cti_q, cti_d;
   logic                         burst_q, burst_d;
   logic [`MAM_BEATS_WIDTH-1:0]  beats_q, beats_d;   // Beats not yet completed
   logic [`MAM_ADDR_WIDTH-1:0]   addr_q, addr_d;
   logic [`MAM_DATA_WIDTH-1:0]   dat_q, dat_d;
   logic [`MAM_SEL_WIDTH-1:0]    sel_q, sel_d;
   logic [`MAM_DATA_WIDTH-1:0]   rdata_q, rdata_d;
   logic                         req_multi;          // Request needs more than one beat

   assign req_multi = req.burst && (req.beats != BEATS_ONE);

   // Control state
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         we_q    <= 1'b0;
         cti_q   <= CTI_CLASSIC;
      end else begin
         state_q <= state_d;
         cyc_q   <= cyc_d;
         stb_q   <= stb_d;
         we_q    <= we_d;
         cti_q   <= cti_d;
      end
   end

   // Datapath registers
   always_ff @(posedge clk_i) begin
      burst_q <= burst_d;
      beats_q <= beats_d;
      addr_q  <= addr_d;
      dat_q   <= dat_d;
      sel_q   <= sel_d;
      rdata_q <= rdata_d;
   end

   always_comb begin
      state_d = state_q;
      cyc_d   = cyc_q;
      stb_d   = stb_q;
      we_d    = we_q;
      cti_d   = cti_q;
      burst_d = burst_q;
      beats_d = beats_q;
      addr_d  = addr_q;
      dat_d   = dat_q;
      sel_d   = sel_q;
      rdata_d = rdata_q;

      req.req_ready = 1'b0;
      write_ready_o = 1'b0;
      read_valid_o  = 1'b0;

      case (state_q)
         S_IDLE: begin
            req.req_ready = 1'b1;
            if (req.req_valid) begin
               cyc_d   = 1'b1;
               we_d    = (req.op == OP_WRITE);
               burst_d = req.burst;
               addr_d  = req.addr;
               sel_d   = '1;
               beats_d = req.burst ? req.beats : BEATS_ONE;   // Single access is one beat
               cti_d   = req_multi ? CTI_INCR : CTI_EOB;
               if (req.op == OP_WRITE) begin
                  state_d = req_multi ? S_WRITE_WAIT : S_WRITE_LAST_WAIT;
               end else begin
                  state_d = S_READ_START;
               end
            end
         end

         S_WRITE_WAIT: begin
            write_ready_o = 1'b1;
            if (write_valid_i) begin
               dat_d   = write_data_i;
               stb_d   = 1'b1;
               state_d = S_WRITE;
            end
         end

         S_WRITE: begin
            if (wb.ack) begin
               write_ready_o = 1'b1;   // Next beat may ride on this ack
               addr_d  = addr_q + ADDR_STEP;
               beats_d = beats_q - 1'b1;
               if (beats_d == BEATS_ONE) begin
                  cti_d = CTI_EOB;
                  if (write_valid_i) begin
                     dat_d   = write_data_i;
                     state_d = S_WRITE_LAST;
                  end else begin
                     stb_d   = 1'b0;
                     state_d = S_WRITE_LAST_WAIT;
                  end
               end else if (write_valid_i) begin
                  dat_d = write_data_i;   // Stay in S_WRITE with stb held
               end else begin
                  stb_d   = 1'b0;
                  state_d = S_WRITE_WAIT;
               end
            end
         end

         S_WRITE_LAST_WAIT: begin
            write_ready_o = 1'b1;
            if (write_valid_i) begin
               dat_d   = write_data_i;
               stb_d   = 1'b1;
               state_d = S_WRITE_LAST;
               if (!burst_q) begin
                  sel_d = write_strb_i;
               end
            end
         end

         S_WRITE_LAST: begin
            if (wb.ack) begin
               cyc_d   = 1'b0;
               stb_d   = 1'b0;
               we_d    = 1'b0;
               cti_d   = CTI_CLASSIC;
               state_d = S_IDLE;
            end
         end

         S_READ_START: begin
            stb_d   = 1'b1;
            state_d = (beats_q == BEATS_ONE) ? S_READ_LAST_BURST : S_READ;
         end

         S_READ: begin
            if (wb.ack) begin
               rdata_d = wb.dat_s2m;
               stb_d   = 1'b0;   // No fetch while the beat is waiting
               addr_d  = addr_q + ADDR_STEP;
               beats_d = beats_q - 1'b1;
               state_d = S_READ_WAIT;
            end
         end

         S_READ_WAIT: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               stb_d = 1'b1;
               if (beats_q == BEATS_ONE) begin
                  cti_d   = CTI_EOB;
                  state_d = S_READ_LAST_BURST;
               end else begin
                  state_d = S_READ;
               end
            end
         end

         // Final beat of bursts and single reads
         S_READ_LAST_BURST: begin
            if (wb.ack) begin
               rdata_d = wb.dat_s2m;
               stb_d   = 1'b0;
               state_d = S_READ_LAST_WAIT;
            end
         end

         S_READ_LAST_WAIT: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               cyc_d   = 1'b0;
               cti_d   = CTI_CLASSIC;
               state_d = S_IDLE;
            end
         end

         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   assign wb.cyc     = cyc_q;
   assign wb.stb     = stb_q;
   assign wb.we      = we_q;
   assign wb.addr    = addr_q;
   assign wb.dat_m2s = dat_q;
   assign wb.sel     = sel_q;
   assign wb.cti     = cti_q;
   assign wb.bte     = 2'b00;   // Linear bursts only

   assign read_data_o = rdata_q;

endmodule

/* rtl/wb_sram.sv */
/*
 * Wishbone slave word memory with programmable wait states,
 * byte lane writes and address wrap within its depth
 */
`timescale 1ns/1ns
`include "mam_config.svh"

module wb_sram (
   input  logic     clk_i,
   input  logic     rst_i,
   wb_bus_if.slave  wb
);

   localparam int DEPTH   = 1 << `MAM_MEM_WORDS_LOG2;
   localparam int LSB     = $clog2(`MAM_SEL_WIDTH);      // Byte offset bits
   localparam int WAIT_W  = $clog2(`MAM_WB_WAIT + 2);
   localparam logic [WAIT_W-1:0] WAIT_CYCLES = `MAM_WB_WAIT;

   logic [`MAM_DATA_WIDTH-1:0]    mem [DEPTH];
   logic [`MAM_MEM_WORDS_LOG2-1:0] word_idx;
   logic [WAIT_W-1:0]             wait_cnt;
   logic                          ack_q;
   logic [`MAM_DATA_WIDTH-1:0]    rdata_q;
   logic                          beat_req;   // Strobe not yet acknowledged
   logic                          ack_next;

   // Upper address bits dropped, so accesses wrap
   assign word_idx = wb.addr[LSB +: `MAM_MEM_WORDS_LOG2];
   assign beat_req = wb.cyc && wb.stb && !ack_q;
   assign ack_next = beat_req && (wait_cnt == WAIT_CYCLES);

   // Wait counter restarts for every beat
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q    <= 1'b0;
         wait_cnt <= '0;
      end else if (ack_next) begin
         ack_q    <= 1'b1;
         wait_cnt <= '0;
      end else if (beat_req) begin
         ack_q    <= 1'b0;
         wait_cnt <= wait_cnt + 1'b1;
      end else begin
         ack_q    <= 1'b0;
         wait_cnt <= '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (ack_next) begin
         rdata_q <= mem[word_idx];   // Presented together with ack
      end
      if (ack_q && wb.stb && wb.we) begin
         for (int i = 0; i < `MAM_SEL_WIDTH; i++) begin
            if (wb.sel[i]) begin
               mem[word_idx][8*i +: 8] <= wb.dat_m2s[8*i +: 8];
            end
         end
      end
   end

   assign wb.ack     = ack_q;
   assign wb.dat_s2m = rdata_q;

endmodule

/* rtl/mam_wb_top.sv */
/*
 * Top level of the debug memory access path: request,
 * write and read streams as plain ports, engine and memory
 */
`timescale 1ns/1ns
`include "mam_config.svh"

module mam_wb_top import mam_pkg::*; (
   input  logic                        clk_i,
   input  logic                        rst_i,

   // Request channel
   input  logic                        req_valid_i,
   output logic                        req_ready_o,
   input  logic                        req_rw_i,      // 1 for write
   input  logic [`MAM_ADDR_WIDTH-1:0]  req_addr_i,
   input  logic                        req_burst_i,
   input  logic [`MAM_BEATS_WIDTH-1:0] req_beats_i,

   // Write stream
   input  logic                        write_valid_i,
   input  logic [`MAM_DATA_WIDTH-1:0]  write_data_i,
   input  logic [`MAM_SEL_WIDTH-1:0]   write_strb_i,
   output logic                        write_ready_o,

   // Read stream
   output logic                        read_valid_o,
   output logic [`MAM_DATA_WIDTH-1:0]  read_data_o,
   input  logic                        read_ready_i
);

   mam_req_if req_bus ();
   wb_bus_if  wb_bus ();

   assign req_bus.req_valid = req_valid_i;
   assign req_bus.op        = req_rw_i ? OP_WRITE : OP_READ;
   assign req_bus.addr      = req_addr_i;
   assign req_bus.burst     = req_burst_i;
   assign req_bus.beats     = req_beats_i;
   assign req_ready_o       = req_bus.req_ready;

   mam_wb_master u_master (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req           (req_bus),
      .write_valid_i (write_valid_i),
      .write_data_i  (write_data_i),
      .write_strb_i  (write_strb_i),
      .write_ready_o (write_ready_o),
      .read_valid_o  (read_valid_o),
      .read_data_o   (read_data_o),
      .read_ready_i  (read_ready_i),
      .wb            (wb_bus)
   );

   wb_sram u_sram (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .wb    (wb_bus)
   );

endmodule

/* tests/mam_wb_properties.sv */
/*
 * Concurrent assertions on the engine's Wishbone master side,
 * request channel and read stream, bound into the engine
 */
`timescale 1ns/1ns
`include "mam_config.svh"

module mam_wb_properties import mam_pkg::*; (
   input logic                        clk_i,
   input logic                        rst_i,
   input logic                        cyc_i,
   input logic                        stb_i,
   input logic                        we_i,
   input logic                        ack_i,
   input logic [`MAM_ADDR_WIDTH-1:0]  addr_i,
   input logic [`MAM_DATA_WIDTH-1:0]  dat_i,
   input logic [`MAM_SEL_WIDTH-1:0]   sel_i,
   input wb_cti_t                     cti_i,
   input logic [`MAM_BEATS_WIDTH-1:0] beats_i,   // Beats left in the engine
   input logic                        req_ready_i,
   input logic                        read_valid_i,
   input logic                        read_ready_i,
   input logic [`MAM_DATA_WIDTH-1:0]  read_data_i
);

   stb_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
      else $error("stb high outside a bus cycle");

   // Beat held until the slave acknowledges
   beat_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && !ack_i |=> $stable(addr_i) && $stable(dat_i) && $stable(sel_i) && $stable(we_i))
      else $error("address or data changed during a pending beat");

   read_held: assert property (@(posedge clk_i) disable iff (rst_i)
      read_valid_i && !read_ready_i |=> read_valid_i && $stable(read_data_i))
      else $error("read beat dropped or changed before read_ready");

   busy_not_ready: assert property (@(posedge clk_i) disable iff (rst_i) cyc_i |-> !req_ready_i)
      else $error("req_ready high during a bus cycle");

   last_beat_eob: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && ack_i && (beats_i == 1) |-> cti_i == CTI_EOB)
      else $error("last beat without end-of-burst cycle type");

endmodule

bind mam_wb_master mam_wb_properties u_props (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .cyc_i        (wb.cyc),
   .stb_i        (wb.stb),
   .we_i         (wb.we),
   .ack_i        (wb.ack),
   .addr_i       (wb.addr),
   .dat_i        (wb.dat_m2s),
   .sel_i        (wb.sel),
   .cti_i        (wb.cti),
   .beats_i      (beats_q),
   .req_ready_i  (req.req_ready),
   .read_valid_i (read_valid_o),
   .read_ready_i (read_ready_i),
   .read_data_i  (read_data_o)
);

/* tests/tb_mam_wb.sv */
/*
 * Testbench of the memory access path: clock, reset, LFSR,
 * byte-merged reference memory, read/write tests, checks and timeout
 */
`timescale 1ns/1ns
`include "mam_config.svh"

module tb_mam_wb;

   localparam int DW    = `MAM_DATA_WIDTH;
   localparam int AW    = `MAM_ADDR_WIDTH;
   localparam int SW    = `MAM_SEL_WIDTH;
   localparam int BW    = `MAM_BEATS_WIDTH;
   localparam int DEPTH = 1 << `MAM_MEM_WORDS_LOG2;
   localparam int LSB   = $clog2(SW);

   // Run limit from all beats of all tests at worst bus time plus gap
   localparam int TOTAL_BEATS = 60;
   localparam int TXNS        = 15;                  // Requests over all tests
   localparam int GAP_MAX     = 3;
   localparam int BEAT_CYCLES = `MAM_WB_WAIT + 3;
   localparam int MAX_CYCLES  = 2 * (TOTAL_BEATS * (BEAT_CYCLES + GAP_MAX) + TXNS * 4) + 10;

   logic          clk_i;
   logic          rst_i;
   logic          req_valid_i;
   logic          req_ready_o;
   logic          req_rw_i;
   logic [AW-1:0] req_addr_i;
   logic          req_burst_i;
   logic [BW-1:0] req_beats_i;
   logic          write_valid_i;
   logic [DW-1:0] write_data_i;
   logic [SW-1:0] write_strb_i;
   logic          write_ready_o;
   logic          read_valid_o;
   logic [DW-1:0] read_data_o;
   logic          read_ready_i;

   logic [15:0]   lfsr_state = 16'd3324;
   logic [DW-1:0] model_mem [DEPTH];       // Expected memory contents
   logic [DW-1:0] exp_q [$];               // Read beats still expected
   logic          bp_en = 1'b0;            // Random read back-pressure
   string         test_name = "";
   int            errors = 0;
   int            checks = 0;
   int            tests = 0;
   int            test_err = 0;
   int            wr_cnt = 0;
   int            rd_cnt = 0;
   int            cycles = 0;

   mam_wb_top dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // Memory wraps at its depth
   function automatic int word_index(input logic [AW-1:0] addr);
      return int'((addr >> LSB) % DEPTH);
   endfunction

   // Strobed lanes take the new byte and the rest keep the old one
   function automatic logic [DW-1:0] expected_word(input logic [DW-1:0] old_w,
                                                   input logic [DW-1:0] new_w,
                                                   input logic [SW-1:0] strb);
      logic [DW-1:0] w;
      w = old_w;
      for (int i = 0; i < SW; i++) begin
         if (strb[i]) begin
            w[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return w;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      checks++;
      if (act_v !== exp_v) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", what, exp_v, act_v);
      end
   endtask

   task automatic do_request(input logic rw, input logic [AW-1:0] addr,
                             input logic burst, input int beats);
      req_valid_i = 1'b1;
      req_rw_i    = rw;
      req_addr_i  = addr;
      req_burst_i = burst;
      req_beats_i = BW'(beats);
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #2 req_valid_i = 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);   // Back in idle ends the transaction
      @(posedge clk_i);
      #2;
   endtask

   task automatic drive_writes(input logic [AW-1:0] addr, input logic burst, input int n,
                               input logic [SW-1:0] strb, input logic gaps);
      logic [DW-1:0] data;
      int            idx;
      for (int i = 0; i < n; i++) begin
         data = DW'(rand_bits(DW));
         if (gaps) begin
            repeat (rand_bits(2)) begin
               @(posedge clk_i);
               #2;
            end
         end
         write_valid_i = 1'b1;
         write_data_i  = data;
         write_strb_i  = strb;
         @(negedge clk_i);
         while (!write_ready_o) @(negedge clk_i);
         idx = word_index(addr + i * SW);
         model_mem[idx] = expected_word(model_mem[idx], data, burst ? {SW{1'b1}} : strb);
         @(posedge clk_i);
         #2 write_valid_i = 1'b0;
      end
   endtask

   task automatic write_txn(input logic [AW-1:0] addr, input logic burst, input int n,
                            input logic [SW-1:0] strb, input logic gaps);
      wr_cnt = 0;
      do_request(1'b1, addr, burst, n);
      drive_writes(addr, burst, n, strb, gaps);
      write_valid_i = 1'b1;   // One beat too many, the engine must not take it
      wait_idle();
      write_valid_i = 1'b0;
      check_value({test_name, " write beats"}, n, wr_cnt);
   endtask

   task automatic read_txn(input logic [AW-1:0] addr, input logic burst, input int n);
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(model_mem[word_index(addr + i * SW)]);
      end
      rd_cnt = 0;
      do_request(1'b0, addr, burst, n);
      wait_idle();
      check_value({test_name, " read beats"}, n, rd_cnt);
      exp_q.delete();
   endtask

   task automatic set_backpressure(input logic on);
      @(negedge clk_i);
      bp_en = on;
      @(posedge clk_i);
      #2;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err  = errors;
   endtask

   task automatic finish_test();
      tests++;
      if (errors == test_err) begin
         $display("Test %s: passed", test_name);
      end else begin
         $display("Test %s: failed with %0d errors", test_name, errors - test_err);
      end
   endtask

   // Handshakes counted mid-cycle and read beats compared in order
   initial begin
      forever begin
         @(negedge clk_i);
         if (!rst_i && write_valid_i && write_ready_o) begin
            wr_cnt++;
         end
         if (!rst_i && read_valid_o && read_ready_i) begin
            rd_cnt++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Test %s: a read beat arrived when none was expected", test_name);
            end else begin
               check_value(test_name, exp_q.pop_front(), read_data_o);
            end
         end
      end
   end

   initial begin
      read_ready_i = 1'b1;
      forever begin
         @(posedge clk_i);
         #2 read_ready_i = bp_en ? (rand_bits(2) != 0) : 1'b1;
      end
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      rst_i         = 1'b1;
      req_valid_i   = 1'b0;
      req_rw_i      = 1'b0;
      req_addr_i    = '0;
      req_burst_i   = 1'b0;
      req_beats_i   = '0;
      write_valid_i = 1'b0;
      write_data_i  = '0;
      write_strb_i  = '0;
      repeat (2) @(posedge clk_i);
      #2 rst_i = 1'b0;

      start_test("single_rw");
      write_txn(32'h10, 1'b0, 1, '1, 1'b0);
      read_txn(32'h10, 1'b0, 1);
      finish_test();

      start_test("partial_strobe");
      write_txn(32'h20, 1'b0, 1, '1, 1'b0);
      write_txn(32'h20, 1'b0, 1, SW'(1), 1'b0);   // Lowest lane only
      read_txn(32'h20, 1'b0, 1);
      finish_test();

      start_test("burst_rw");
      write_txn(32'h40, 1'b1, 8, '1, 1'b0);
      read_txn(32'h40, 1'b1, 8);
      write_txn(32'h80, 1'b1, 1, SW'(1), 1'b0);   // Burst of one writes all lanes
      read_txn(32'h80, 1'b1, 1);
      finish_test();

      start_test("read_backpressure");
      set_backpressure(1'b1);
      read_txn(32'h40, 1'b1, 8);
      set_backpressure(1'b0);
      finish_test();

      start_test("write_gaps");
      write_txn(32'h100, 1'b1, 10, '1, 1'b1);
      read_txn(32'h100, 1'b1, 10);
      finish_test();

      start_test("address_wrap");
      write_txn((DEPTH - 2) * SW, 1'b1, 4, '1, 1'b1);   // Crosses the top word
      read_txn(32'h0, 1'b0, 1);
      set_backpressure(1'b1);
      read_txn((DEPTH - 2) * SW, 1'b1, 4);
      set_backpressure(1'b0);
      finish_test();

      $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* src.f */
+incdir+include
rtl/mam_pkg.sv
rtl/mam_req_if.sv
rtl/wb_bus_if.sv
rtl/mam_wb_master.sv
rtl/wb_sram.sv
rtl/mam_wb_top.sv
tests/mam_wb_properties.sv
tests/tb_mam_wb.sv
